// File: build.f
riscv_isa_pkg.sv
uarch_pkg.sv
inst_buffer.sv
decode.sv
rename.sv
frontend_top.sv
frontend_checker.sv
tb_frontend.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_frontend.sv
// Directed tests for the two-lane front end, BUF_DEPTH fixed at 4
// Expected bundles come from a decode and rename model kept in this file

`timescale 1ns/100ps

module tb_frontend;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;

    logic                   clk;
    logic                   flush;
    logic                   fetch_val;
    uarch_pkg::fetch_pkt_t  fetch_pkt;
    logic                   fetch_rdy;
    logic                   backend_rdy;
    uarch_pkg::ren_bundle_t renamed;
    logic                   out_val;

    uarch_pkg::ren_bundle_t exp_q[$];       // Bundles the backend should see
    uarch_pkg::phys_tag_t   model_map [32];
    uarch_pkg::phys_tag_t   model_ptr;
    logic [31:0]            lfsr = 32'h53d4_08ab;
    int                     errors = 0;

    frontend_top #(.BUF_DEPTH(4)) u_dut (.*);

    bind frontend_top frontend_checker u_chk (
        .clk(clk), .flush(flush), .fetch_rdy(fetch_rdy), .backend_rdy(backend_rdy),
        .renamed(renamed), .out_val(out_val)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    function automatic uarch_pkg::instruction_t model_decode(input logic [31:0] pc,
                                                            input logic [31:0] w);
        uarch_pkg::instruction_t r;
        logic [6:0]  op;
        logic [31:0] imm;
        op = w[6:0];
        r  = '0;
        if (op == riscv_isa_pkg::OPC_ARI_ITYPE) imm = {{20{w[31]}}, w[31:20]};
        else if (op == riscv_isa_pkg::OPC_STORE) imm = {{20{w[31]}}, w[31:25], w[11:7]};
        else if (op == riscv_isa_pkg::OPC_BRANCH)
            imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        else if (op == riscv_isa_pkg::OPC_LUI || op == riscv_isa_pkg::OPC_AUIPC)
            imm = {w[31:12], 12'b0};
        else if (op == riscv_isa_pkg::OPC_JAL || op == riscv_isa_pkg::OPC_JALR)
            imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        else imm = '0;                       // Loads and CSR carry no immediate
        r.pc           = pc;
        r.opcode       = op;
        r.rd           = w[11:7];
        r.src_1_a.data = {27'b0, w[19:15]};
        r.src_1_b.data = {27'b0, w[24:20]};
        r.is_valid     = op inside {riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC,
            riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_BRANCH,
            riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_STORE, riscv_isa_pkg::OPC_ARI_ITYPE,
            riscv_isa_pkg::OPC_ARI_RTYPE, riscv_isa_pkg::OPC_CSR};
        r.has_rd       = op inside {riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC,
            riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_LOAD,
            riscv_isa_pkg::OPC_ARI_ITYPE, riscv_isa_pkg::OPC_ARI_RTYPE};
        r.br_taken     = (op == riscv_isa_pkg::OPC_JAL) || (op == riscv_isa_pkg::OPC_JALR);
        r.src_0_a.data = (op inside {riscv_isa_pkg::OPC_AUIPC, riscv_isa_pkg::OPC_JAL,
            riscv_isa_pkg::OPC_BRANCH}) ? pc : {27'b0, w[19:15]};
        r.src_0_b.data = (op == riscv_isa_pkg::OPC_ARI_RTYPE) ? {27'b0, w[24:20]} : imm;
        if (op inside {riscv_isa_pkg::OPC_ARI_RTYPE, riscv_isa_pkg::OPC_ARI_ITYPE,
                       riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_STORE})
            r.uop_0 = w[14:12];
        if (op == riscv_isa_pkg::OPC_BRANCH) r.uop_1 = w[14:12];
        if (op == riscv_isa_pkg::OPC_ARI_RTYPE ||
            (op == riscv_isa_pkg::OPC_ARI_ITYPE && w[14:12] == 3'b101))
            r.funct7 = w[31:25];
        return r;
    endfunction

    // Lanes renamed one after the other, lane 1 sees lane 0's write
    task automatic predict_bundle(input uarch_pkg::fetch_pkt_t p);
        uarch_pkg::ren_bundle_t b;
        b = '0;
        for (int i = 0; i < 2; i++) begin
            b[i].inst = model_decode(p.pc[i], p.inst[i]);
            b[i].prs1 = model_map[p.inst[i][19:15]];
            b[i].prs2 = model_map[p.inst[i][24:20]];
            if (b[i].inst.is_valid && b[i].inst.has_rd && b[i].inst.rd != 0) begin
                b[i].pdst = model_ptr;
                model_map[b[i].inst.rd] = model_ptr;
                model_ptr = (model_ptr == 63) ? 6'd32 : model_ptr + 1'b1;
            end
        end
        if (b[0].inst.is_valid || b[1].inst.is_valid) exp_q.push_back(b);
    endtask

    // Bundle leaves on an edge with backend_rdy high
    always @(posedge clk) begin
        if (!flush && backend_rdy && out_val) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected bundle on renamed at %0t", $time);
            end else begin
                for (int i = 0; i < 2; i++) begin
                    assert (renamed[i] == exp_q[0][i]) else begin
                        errors++;
                        $display("ERR %0t renamed[%0d] exp %h got %h", $time, i,
                                 exp_q[0][i], renamed[i]);
                    end
                end
                void'(exp_q.pop_front());
            end
        end
    end

    //----------------------------------------------------------------------
    // Drivers, entered 2 ns after a rising edge
    //----------------------------------------------------------------------
    task automatic send(input logic [31:0] pc, input logic [31:0] w0, input logic [31:0] w1);
        while (!fetch_rdy) begin
            @(posedge clk);
            #2;
        end
        fetch_pkt.pc[0]   = pc;
        fetch_pkt.pc[1]   = pc + 4;
        fetch_pkt.inst[0] = w0;
        fetch_pkt.inst[1] = w1;
        fetch_val         = 1'b1;
        predict_bundle(fetch_pkt);
        @(posedge clk);
        #2;
        fetch_val = 1'b0;
    endtask

    task automatic apply_flush();
        flush = 1'b1;
        exp_q.delete();
        repeat (4) begin
            @(posedge clk);
            assert (!out_val && fetch_rdy) else begin
                errors++;
                $display("ERR %0t out_val/fetch_rdy exp 0/1 got %b/%b", $time, out_val,
                         fetch_rdy);
            end
        end
        #2;
        flush = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_map[i] = uarch_pkg::phys_tag_t'(i);
        end
        model_ptr = 6'd32;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 60) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Expected bundles never left the front end at %0t", $time);
        end
    endtask

    function automatic logic [31:0] add_r(input int rd, input int rs1, input int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), riscv_isa_pkg::OPC_ARI_RTYPE};
    endfunction

    //----------------------------------------------------------------------
    // Tests
    //----------------------------------------------------------------------
    task automatic chain_renames();
        send(32'h100, add_r(5, 1, 2), add_r(6, 5, 5));   // Lane 1 bypass
        send(32'h108, add_r(5, 6, 0), add_r(0, 5, 5));   // x0 allocates nothing
        send(32'h110, add_r(7, 5, 6), add_r(7, 7, 7));
        drain();
    endtask

    task automatic decode_formats();
        logic [6:0] ops [10];
        ops = '{riscv_isa_pkg::OPC_ARI_ITYPE, riscv_isa_pkg::OPC_STORE,
                riscv_isa_pkg::OPC_BRANCH, riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC,
                riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_LOAD,
                riscv_isa_pkg::OPC_ARI_RTYPE, riscv_isa_pkg::OPC_CSR};
        for (int i = 0; i < 10; i++) begin
            send(32'({rand_bits(30), 2'b00}), 32'({rand_bits(25), ops[i]}),
                 32'({rand_bits(25), ops[9-i]}));
        end
        drain();
    endtask

    task automatic illegal_opcodes();
        send(32'h200, 32'({rand_bits(25), 7'h7f}), 32'({rand_bits(25), 7'h00}));
        repeat (5) begin
            @(posedge clk);
            assert (!out_val) else begin
                errors++;
                $display("ERR %0t out_val exp 0 got %b", $time, out_val);
            end
        end
        #2;
        send(32'h300, 32'({rand_bits(25), 7'h7f}), add_r(9, 3, 4));   // Lane 1 only
        drain();
    endtask

    task automatic stall_backend();
        uarch_pkg::ren_bundle_t held;
        int sent;
        int n;
        sent = 0;
        n    = 0;
        send(32'h3f8, add_r(20, 1, 2), add_r(21, 20, 3));   // Parked on renamed
        while (!out_val && n < 10) begin
            @(posedge clk);
            #2;
            n++;
        end
        backend_rdy = 1'b0;
        while (fetch_rdy && sent < 8) begin
            send(32'h400 + 8 * sent, add_r(10 + sent, sent, 10 + sent), add_r(3, 10 + sent, 2));
            sent++;
        end
        assert (sent == 4) else begin
            errors++;
            $display("ERR %0t packets_before_stall exp 4 got %0d", $time, sent);
        end
        held = renamed;
        repeat (5) begin
            @(posedge clk);
            assert (renamed == held) else begin
                errors++;
                $display("ERR %0t renamed exp %h got %h", $time, held, renamed);
            end
        end
        #2;
        backend_rdy = 1'b1;
        drain();
    endtask

    task automatic flush_midstream();
        send(32'h500, add_r(11, 1, 2), add_r(12, 11, 3));
        send(32'h508, add_r(13, 12, 4), add_r(14, 13, 5));
        apply_flush();                                   // Mid-stream
        send(32'h600, add_r(5, 1, 2), add_r(6, 3, 4));
        drain();
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * 20);
        $display("Watchdog expired before the tests finished at %0t", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        flush       = 1'b1;
        fetch_val   = 1'b0;
        fetch_pkt   = '0;
        backend_rdy = 1'b1;
        #2;
        apply_flush();
        chain_renames();
        decode_formats();
        illegal_opcodes();
        stall_backend();
        flush_midstream();
        $display("Run complete, errors = %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: frontend_checker.sv
// Bound into frontend_top, watches reset levels and output hold under stall
// Stability check is skipped while flush is high

`timescale 1ns/100ps

module frontend_checker (
    input logic                   clk,
    input logic                   flush,
    input logic                   fetch_rdy,
    input logic                   backend_rdy,
    input uarch_pkg::ren_bundle_t renamed,
    input logic                   out_val
);

    // Flush clears the output register at once
    a_no_out_in_flush: assert property (@(posedge clk) flush |-> !out_val)
        else $error("out_val high during flush");

    // Empty buffer after flush
    a_rdy_in_flush: assert property (@(posedge clk) flush |-> fetch_rdy)
        else $error("fetch_rdy low during flush");

    // Held bundle must not move while backend stalls
    a_hold_on_stall: assert property (@(posedge clk) disable iff (flush)
        !backend_rdy |=> $stable(renamed))
        else $error("renamed changed while backend_rdy low");

endmodule

// File: frontend_top.sv
// Buffer, decode and rename in series, two cycles from buffer head to output
// Stall flows backwards as a level from backend_rdy

`timescale 1ns/100ps

module frontend_top #(
    parameter int BUF_DEPTH = 4             // Power of two, 2 or more
) (
    input  logic                   clk,
    input  logic                   flush,
    input  logic                   fetch_val,
    input  uarch_pkg::fetch_pkt_t  fetch_pkt,
    output logic                   fetch_rdy,
    input  logic                   backend_rdy,
    output uarch_pkg::ren_bundle_t renamed,
    output logic                   out_val
);

    // ------------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------------
    logic                    buf_val;
    uarch_pkg::fetch_pkt_t   buf_pkt;
    logic                    decode_rdy;
    logic                    rename_rdy;
    uarch_pkg::inst_bundle_t decoded_insts;

    inst_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
        .clk        (clk),
        .flush      (flush),
        .fetch_val  (fetch_val),
        .fetch_pkt  (fetch_pkt),
        .fetch_rdy  (fetch_rdy),
        .buf_val    (buf_val),
        .buf_pkt    (buf_pkt),
        .decode_rdy (decode_rdy)
    );

    decode u_decode (
        .clk           (clk),
        .flush         (flush),
        .buf_val       (buf_val),
        .buf_pkt       (buf_pkt),
        .decode_rdy    (decode_rdy),
        .rename_rdy    (rename_rdy),
        .decoded_insts (decoded_insts)
    );

    rename u_rename (
        .clk           (clk),
        .flush         (flush),
        .decoded_insts (decoded_insts),
        .rename_rdy    (rename_rdy),
        .backend_rdy   (backend_rdy),
        .renamed       (renamed),
        .out_val       (out_val)
    );

endmodule

// File: rename.sv
// Map table rename with a wrapping tag allocator, tags are never reclaimed
// Tags 0..31 hold the reset identity map, allocation cycles through 32..63

`timescale 1ns/100ps

module rename (
    input  logic                    clk,
    input  logic                    flush,
    // From decode
    input  uarch_pkg::inst_bundle_t decoded_insts,
    output logic                    rename_rdy,
    // To backend
    input  logic                    backend_rdy,
    output uarch_pkg::ren_bundle_t  renamed,
    output logic                    out_val
);

    localparam uarch_pkg::phys_tag_t FIRST_FREE_TAG =
        uarch_pkg::phys_tag_t'(riscv_isa_pkg::NUM_ARCH_REGS);

    uarch_pkg::phys_tag_t map_table [riscv_isa_pkg::NUM_ARCH_REGS];
    uarch_pkg::phys_tag_t alloc_ptr;        // Next tag to hand out
    uarch_pkg::phys_tag_t ptr_mid;          // After lane 0
    uarch_pkg::phys_tag_t ptr_next;         // After lane 1

    logic [riscv_isa_pkg::REG_ADDR_BITS-1:0] rs1 [uarch_pkg::PIPE_WIDTH];
    logic [riscv_isa_pkg::REG_ADDR_BITS-1:0] rs2 [uarch_pkg::PIPE_WIDTH];
    logic [riscv_isa_pkg::REG_ADDR_BITS-1:0] rd  [uarch_pkg::PIPE_WIDTH];
    logic [uarch_pkg::PIPE_WIDTH-1:0]        alloc;

    uarch_pkg::ren_bundle_t renamed_next;

    // Wrap 63 back to 32, arch identity tags stay untouched
    function automatic uarch_pkg::phys_tag_t next_tag(input uarch_pkg::phys_tag_t t);
        return (t == '1) ? FIRST_FREE_TAG : t + 1'b1;
    endfunction

    assign rename_rdy = backend_rdy;

    // ------------------------------------------------------------------
    // Tag lookup and allocation
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < uarch_pkg::PIPE_WIDTH; i++) begin
            rs1[i]   = decoded_insts[i].src_1_a.tag.idx;
            rs2[i]   = decoded_insts[i].src_1_b.tag.idx;
            rd[i]    = decoded_insts[i].rd;
            alloc[i] = decoded_insts[i].is_valid && decoded_insts[i].has_rd && (rd[i] != '0);
        end

        ptr_mid  = alloc[0] ? next_tag(alloc_ptr) : alloc_ptr;
        ptr_next = alloc[1] ? next_tag(ptr_mid) : ptr_mid;

        // Lane 0 reads the table as is
        renamed_next[0].inst = decoded_insts[0];
        renamed_next[0].pdst = alloc[0] ? alloc_ptr : '0;
        renamed_next[0].prs1 = map_table[rs1[0]];
        renamed_next[0].prs2 = map_table[rs2[0]];

        // Lane 1 sees lane 0's new mapping
        renamed_next[1].inst = decoded_insts[1];
        renamed_next[1].pdst = alloc[1] ? ptr_mid : '0;
        renamed_next[1].prs1 = (alloc[0] && rs1[1] == rd[0]) ? renamed_next[0].pdst
                                                             : map_table[rs1[1]];
        renamed_next[1].prs2 = (alloc[0] && rs2[1] == rd[0]) ? renamed_next[0].pdst
                                                             : map_table[rs2[1]];
    end

    // ------------------------------------------------------------------
    // State update, only when the backend takes the bundle
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge flush) begin
        if (flush) begin
            for (int i = 0; i < riscv_isa_pkg::NUM_ARCH_REGS; i++) begin
                map_table[i] <= uarch_pkg::phys_tag_t'(i);  // Identity
            end
            alloc_ptr <= FIRST_FREE_TAG;
            renamed   <= '0;
        end else if (backend_rdy) begin
            if (alloc[0]) begin
                map_table[rd[0]] <= renamed_next[0].pdst;
            end
            if (alloc[1]) begin
                map_table[rd[1]] <= renamed_next[1].pdst;   // Later lane wins
            end
            alloc_ptr <= ptr_next;
            renamed   <= renamed_next;
        end
    end

    assign out_val = renamed[0].inst.is_valid | renamed[1].inst.is_valid;

endmodule

// File: decode.sv
// Two-lane RV32I decoder with one register stage toward rename
// Loads and CSR ops carry a zero immediate, JALR uses the J layout

`timescale 1ns/100ps

module decode (
    input  logic                    clk,
    input  logic                    flush,
    // From instruction buffer
    input  logic                    buf_val,
    input  uarch_pkg::fetch_pkt_t   buf_pkt,
    output logic                    decode_rdy,
    // To rename
    input  logic                    rename_rdy,
    output uarch_pkg::inst_bundle_t decoded_insts
);

    // ------------------------------------------------------------------
    // Immediate generation
    // ------------------------------------------------------------------
    function automatic logic [riscv_isa_pkg::CPU_DATA_BITS-1:0] gen_imm(
        input logic [riscv_isa_pkg::CPU_INST_BITS-1:0] inst
    );
        case (inst[6:0])
            riscv_isa_pkg::OPC_ARI_ITYPE:                           // I
                return {{20{inst[31]}}, inst[31:20]};
            riscv_isa_pkg::OPC_STORE:                               // S
                return {{20{inst[31]}}, inst[31:25], inst[11:7]};
            riscv_isa_pkg::OPC_BRANCH:                              // B
                return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC:       // U
                return {inst[31:12], 12'b0};
            riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_JALR:        // J for both jumps
                return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                return '0;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Per-lane decode
    // ------------------------------------------------------------------
    function automatic uarch_pkg::instruction_t decode_inst(
        input logic [riscv_isa_pkg::CPU_ADDR_BITS-1:0] pc,
        input logic [riscv_isa_pkg::CPU_INST_BITS-1:0] inst,
        input logic                                    val
    );
        uarch_pkg::instruction_t d;
        logic [2:0]              funct3;
        logic [6:0]              opc;

        funct3 = inst[14:12];
        opc    = inst[6:0];

        d                  = '0;
        d.pc               = pc;
        d.opcode           = opc;
        d.rd               = inst[11:7];
        d.src_1_a.tag.idx  = inst[19:15];   // rs1, upper bits stay zero
        d.src_1_b.tag.idx  = inst[24:20];   // rs2

        // Legal opcode and a live head packet
        case (opc)
            riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC, riscv_isa_pkg::OPC_JAL,
            riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_BRANCH, riscv_isa_pkg::OPC_LOAD,
            riscv_isa_pkg::OPC_STORE, riscv_isa_pkg::OPC_ARI_ITYPE,
            riscv_isa_pkg::OPC_ARI_RTYPE, riscv_isa_pkg::OPC_CSR:
                d.is_valid = val;
            default:
                d.is_valid = 1'b0;
        endcase

        // Writes a destination
        case (opc)
            riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC, riscv_isa_pkg::OPC_JAL,
            riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_LOAD,
            riscv_isa_pkg::OPC_ARI_ITYPE, riscv_isa_pkg::OPC_ARI_RTYPE:
                d.has_rd = 1'b1;
            default:
                d.has_rd = 1'b0;
        endcase

        d.br_taken = (opc == riscv_isa_pkg::OPC_JAL) || (opc == riscv_isa_pkg::OPC_JALR);

        // First operand, PC-relative ops take the PC
        case (opc)
            riscv_isa_pkg::OPC_AUIPC, riscv_isa_pkg::OPC_JAL, riscv_isa_pkg::OPC_BRANCH:
                d.src_0_a.data    = pc;
            default:
                d.src_0_a.tag.idx = inst[19:15];
        endcase

        // Second operand
        if (opc == riscv_isa_pkg::OPC_ARI_RTYPE) begin
            d.src_0_b.tag.idx = inst[24:20];
        end else begin
            d.src_0_b.data    = gen_imm(inst);
        end

        // ALU op
        case (opc)
            riscv_isa_pkg::OPC_ARI_RTYPE, riscv_isa_pkg::OPC_ARI_ITYPE,
            riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_STORE:
                d.uop_0 = funct3;
            default:
                d.uop_0 = riscv_isa_pkg::FNC_ADD_SUB;
        endcase

        d.uop_1 = (opc == riscv_isa_pkg::OPC_BRANCH) ? funct3 : 3'b000;

        // funct7 only where it selects the op (SUB, SRA)
        if (opc == riscv_isa_pkg::OPC_ARI_RTYPE ||
            (opc == riscv_isa_pkg::OPC_ARI_ITYPE && funct3 == riscv_isa_pkg::FNC_SRL_SRA)) begin
            d.funct7 = inst[31:25];
        end

        return d;
    endfunction

    uarch_pkg::inst_bundle_t decoded_next;

    assign decode_rdy = rename_rdy;         // Stall passes straight back

    always_comb begin
        for (int i = 0; i < uarch_pkg::PIPE_WIDTH; i++) begin
            decoded_next[i] = decode_inst(buf_pkt.pc[i], buf_pkt.inst[i], buf_val);
        end
    end

    // Pipeline register, bubbles load as all-zero records
    always_ff @(posedge clk or posedge flush) begin
        if (flush) begin
            decoded_insts <= '0;
        end else if (decode_rdy) begin
            decoded_insts <= buf_val ? decoded_next : '0;
        end
    end

endmodule

// File: inst_buffer.sv
// Fetch packet queue, BUF_DEPTH must be a power of two (2 or more)
// A packet offered while fetch_rdy is low is dropped

`timescale 1ns/100ps

module inst_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  flush,
    // Fetch side
    input  logic                  fetch_val,    // One-cycle strobe
    input  uarch_pkg::fetch_pkt_t fetch_pkt,
    output logic                  fetch_rdy,
    // Decode side
    output logic                  buf_val,
    output uarch_pkg::fetch_pkt_t buf_pkt,
    input  logic                  decode_rdy
);

    localparam int PTR_BITS = $clog2(BUF_DEPTH);
    localparam int CNT_BITS = $clog2(BUF_DEPTH + 1);

    uarch_pkg::fetch_pkt_t mem [BUF_DEPTH];     // Packet storage

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;                 // Packets held
    logic                push;
    logic                pop;

    // ------------------------------------------------------------------
    // Status and head
    // ------------------------------------------------------------------
    assign fetch_rdy = (count < CNT_BITS'(BUF_DEPTH));
    assign buf_val   = (count != '0);
    assign buf_pkt   = mem[rd_ptr];             // Head, valid with buf_val

    assign push = fetch_val && fetch_rdy;
    assign pop  = buf_val && decode_rdy;

    // Storage write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fetch_pkt;
        end
    end

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge flush) begin
        if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;        // Wraps at power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle, or push and pop together
            endcase
        end
    end

endmodule

// File: uarch_pkg.sv
// Front-end datapath types for a fixed two-lane pipe
// Operand words are 32 bits, register indices live in the low 5 bits

package uarch_pkg;

    localparam int PIPE_WIDTH    = 2;   // Lanes per bundle
    localparam int PHYS_TAG_BITS = 6;   // 64 physical registers

    typedef logic [PHYS_TAG_BITS-1:0] phys_tag_t;

    // ------------------------------------------------------------------
    // Operands
    // ------------------------------------------------------------------
    // Register reference view of an operand word
    typedef struct packed {
        logic [riscv_isa_pkg::CPU_DATA_BITS-riscv_isa_pkg::REG_ADDR_BITS-1:0] zero;
        logic [riscv_isa_pkg::REG_ADDR_BITS-1:0]                              idx;
    } reg_ref_t;

    // Same word, read as immediate/PC or as a register index
    typedef union packed {
        logic [riscv_isa_pkg::CPU_DATA_BITS-1:0] data;
        reg_ref_t                                tag;
    } operand_t;

    // Decoded instruction record
    typedef struct packed {
        logic [riscv_isa_pkg::CPU_ADDR_BITS-1:0] pc;
        logic [6:0]                              opcode;
        logic [riscv_isa_pkg::REG_ADDR_BITS-1:0] rd;
        logic                                    has_rd;
        logic [2:0]                              uop_0;     // ALU op
        logic [2:0]                              uop_1;     // Branch compare
        logic [6:0]                              funct7;
        logic                                    br_taken;  // Unconditional jumps
        logic                                    is_valid;
        operand_t                                src_0_a;   // PC or rs1
        operand_t                                src_0_b;   // rs2 or immediate
        operand_t                                src_1_a;   // Always rs1
        operand_t                                src_1_b;   // Always rs2
    } instruction_t;

    // ------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [PIPE_WIDTH-1:0][riscv_isa_pkg::CPU_ADDR_BITS-1:0] pc;
        logic [PIPE_WIDTH-1:0][riscv_isa_pkg::CPU_INST_BITS-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        instruction_t inst;
        phys_tag_t    pdst;     // Zero when nothing allocated
        phys_tag_t    prs1;
        phys_tag_t    prs2;
    } renamed_t;

    typedef instruction_t [PIPE_WIDTH-1:0] inst_bundle_t;
    typedef renamed_t     [PIPE_WIDTH-1:0] ren_bundle_t;

endpackage

// File: riscv_isa_pkg.sv
// RV32I base encodings only, no compressed or extension opcodes
// Widths are fixed at 32 bits throughout

package riscv_isa_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int CPU_INST_BITS = 32;          // Instruction word
    localparam int CPU_ADDR_BITS = 32;          // PC
    localparam int CPU_DATA_BITS = 32;          // Register and immediate data

    // Architectural register file
    localparam int REG_ADDR_BITS = 5;
    localparam int NUM_ARCH_REGS = 32;          // x0..x31

    // ------------------------------------------------------------------
    // Major opcodes, inst[6:0]
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;  // BEQ..BGEU
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_ARI_ITYPE = 7'b0010011;  // ADDI, shifts by imm
    localparam logic [6:0] OPC_ARI_RTYPE = 7'b0110011;  // Reg-reg ALU ops
    localparam logic [6:0] OPC_CSR       = 7'b1110011;  // SYSTEM space

    // ------------------------------------------------------------------
    // funct3 codes, inst[14:12]
    // ------------------------------------------------------------------
    // Default ALU op for address and link arithmetic
    localparam logic [2:0] FNC_ADD_SUB = 3'b000;

    // Right shifts, funct7 picks logical or arithmetic
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;

endpackage
